// File: Makefile
# Verilator flow for the split cache controller

VERILATOR ?= verilator
TB_TOP    ?= tb_split_cache
RTL_TOP   ?= split_cache_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
FAIL_MSG  ?= TESTBENCH FAILED
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cache_checker.sv
// Split cache response checker
`timescale 1ns/100ps

module cache_checker (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               cmd_valid_i,
    input  logic [8*12-1:0]    exp_name_i,
    input  cache_pkg::rsp_t    exp_rsp_i,
    input  cache_pkg::stats_t  exp_stats_i,
    input  logic               rsp_valid_i,
    input  cache_pkg::rsp_t    rsp_i,
    input  cache_pkg::stats_t  stats_i,
    output int                 pending_o,
    output int                 mismatch_count_o,
    output int                 missing_count_o,
    output int                 spurious_count_o
);

    import cache_pkg::*;

    // Expectation with the cycle its response is due
    typedef struct packed {
        logic [8*12-1:0] name;
        rsp_t            rsp;
        stats_t          stats;
        int              due;
    } expect_t;

    expect_t exp_q[$];
    int      cycle = 0;
    int      pushed = 0;
    int      popped = 0;
    int      mismatches = 0;
    int      missing = 0;
    int      spurious = 0;

    assign pending_o        = pushed - popped;
    assign mismatch_count_o = mismatches;
    assign missing_count_o  = missing;
    assign spurious_count_o = spurious;

    function automatic string mesi_text(input mesi_e m);
        case (m)
            I:       return "I";
            S:       return "S";
            E:       return "E";
            default: return "M";
        endcase
    endfunction

    function automatic string rsp_text(input rsp_t r);
        return $sformatf("hit=%0b way=%0d mesi=%s dirty=%0b instr=%0b",
                         r.hit, r.way, mesi_text(r.mesi), r.victim_dirty, r.is_instr);
    endfunction

    // Commands sampled at the rising edge
    // Response registered one edge later and checked at the following falling edge
    always @(posedge clk_i) begin
        expect_t e;
        cycle = cycle + 1;
        if (rst_n_i && cmd_valid_i) begin
            e.name  = exp_name_i;
            e.rsp   = exp_rsp_i;
            e.stats = exp_stats_i;
            e.due   = cycle + 1;
            exp_q.push_back(e);
            pushed = pushed + 1;
        end
    end

    // Outputs sampled mid-cycle where they are stable
    always @(negedge clk_i) begin
        expect_t head;
        if (rst_n_i) begin
            // Anything overdue never got its response
            while (exp_q.size() > 0 && exp_q[0].due < cycle) begin
                head = exp_q.pop_front();
                popped = popped + 1;
                missing = missing + 1;
                $display("Missing response for %0s: no rsp_valid_o 2 cycles after the command",
                         head.name);
            end
            if (rsp_valid_i === 1'b1) begin
                if (exp_q.size() == 0 || exp_q[0].due != cycle) begin
                    spurious = spurious + 1;
                    $display("Spurious response at cycle %0d: no command 2 cycles earlier", cycle);
                end else begin
                    head = exp_q.pop_front();
                    popped = popped + 1;
                    if (rsp_i !== head.rsp) begin
                        mismatches = mismatches + 1;
                        $display("Mismatch %0s: response expected %s, actual %s",
                                 head.name, rsp_text(head.rsp), rsp_text(rsp_i));
                    end
                    // Counters move in the same cycle as the response
                    if (stats_i !== head.stats) begin
                        mismatches = mismatches + 1;
                        $display({"Mismatch %0s: counts expected hit=%0d miss=%0d,",
                                  " actual hit=%0d miss=%0d"},
                                 head.name, head.stats.hit_count, head.stats.miss_count,
                                 stats_i.hit_count, stats_i.miss_count);
                    end
                end
            end
        end
    end

endmodule

// File: cache_pkg.sv
// Split cache shared definitions
package cache_pkg;

    // Address geometry
    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 6;
    localparam int INDEX_W  = 4;
    localparam int NUM_SETS = 16;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // Associativity per side
    localparam int D_WAYS = 8;
    localparam int I_WAYS = 4;

    // Way number and age width, sized for the wider data side
    localparam int WAY_W = 3;
    localparam int AGE_W = 3;

    // Statistics counter width
    localparam int CNT_W = 16;

    // Line coherence state
    typedef enum logic [1:0] {I, S, E, M} mesi_e;

    // Command operation codes
    typedef enum logic [2:0] {
        OP_READ      = 3'd0,
        OP_WRITE     = 3'd1,
        OP_FETCH     = 3'd2,
        OP_SNOOP_INV = 3'd3,
        OP_SNOOP_RD  = 3'd4
    } op_e;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } address_t;

    // One way of a set, 27 bits
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        mesi_e            mesi;
        logic [AGE_W-1:0] age;
    } cache_line_t;

    typedef cache_line_t [D_WAYS-1:0] d_set_t;
    typedef cache_line_t [I_WAYS-1:0] i_set_t;

    typedef struct packed {
        op_e      op;
        address_t address;
    } command_t;

    typedef struct packed {
        logic             hit;
        logic [WAY_W-1:0] way;
        mesi_e            mesi;
        logic             victim_dirty;
        logic             is_instr;
    } rsp_t;

    typedef struct packed {
        logic [CNT_W-1:0] hit_count;
        logic [CNT_W-1:0] miss_count;
    } stats_t;

    // Cold set: all lines invalid, ages follow way numbers
    function automatic d_set_t cold_set();
        d_set_t lines;
        for (int w = 0; w < D_WAYS; w++) begin
            lines[w].tag  = '0;
            lines[w].mesi = I;
            lines[w].age  = AGE_W'(w);
        end
        return lines;
    endfunction

    localparam d_set_t D_RESET_SET = cold_set();
    // Instruction side keeps the low four ways, ages 0 to 3
    localparam i_set_t I_RESET_SET = D_RESET_SET[I_WAYS-1:0];

endpackage

// File: command_router.sv
// Command decode and response merge
`timescale 1ns/100ps

module command_router (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           cmd_valid_i,
    input  cache_pkg::command_t            cmd_i,
    output logic                           d_rd_en_o,
    output logic                           i_rd_en_o,
    output logic [cache_pkg::INDEX_W-1:0]  rd_index_o,
    output logic                           d_lookup_en_o,
    output logic                           i_lookup_en_o,
    output cache_pkg::command_t            stage_cmd_o,
    input  cache_pkg::rsp_t                d_rsp_i,
    input  cache_pkg::rsp_t                i_rsp_i,
    output logic                           rsp_valid_o,
    output cache_pkg::rsp_t                rsp_o,
    output cache_pkg::stats_t              stats_o
);

    import cache_pkg::*;

    logic     to_data;
    logic     to_instr;
    logic     s1_valid_q;
    logic     s1_d_en_q;
    logic     s1_i_en_q;
    command_t s1_cmd_q;
    logic     s1_snoop;
    logic     s1_counted;
    rsp_t     merged;

    // Stage 0 decode
    always_comb begin
        to_data  = 1'b0;
        to_instr = 1'b0;
        case (cmd_i.op)
            OP_READ, OP_WRITE: to_data = 1'b1;
            OP_FETCH: to_instr = 1'b1;
            // Snoops probe both sides
            OP_SNOOP_INV, OP_SNOOP_RD: begin
                to_data  = 1'b1;
                to_instr = 1'b1;
            end
            default: begin
                to_data  = 1'b0;
                to_instr = 1'b0;
            end
        endcase
    end

    assign d_rd_en_o  = cmd_valid_i && to_data;
    assign i_rd_en_o  = cmd_valid_i && to_instr;
    // Both stores share one index bus
    assign rd_index_o = cmd_i.address.index;

    // Stage 1 control
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s1_d_en_q  <= 1'b0;
            s1_i_en_q  <= 1'b0;
        end else begin
            s1_valid_q <= cmd_valid_i;
            s1_d_en_q  <= d_rd_en_o;
            s1_i_en_q  <= i_rd_en_o;
        end
    end

    // Stage 1 command, lines up with the registered set
    always_ff @(posedge clk_i) begin
        if (cmd_valid_i) begin
            s1_cmd_q <= cmd_i;
        end
    end

    assign d_lookup_en_o = s1_d_en_q;
    assign i_lookup_en_o = s1_i_en_q;
    assign stage_cmd_o   = s1_cmd_q;

    assign s1_snoop   = s1_cmd_q.op inside {OP_SNOOP_INV, OP_SNOOP_RD};
    assign s1_counted = s1_valid_q && !s1_snoop;

    // Merge side responses
    always_comb begin
        if (s1_snoop) begin
            // Data side reports its way when it holds the line
            merged              = d_rsp_i.hit ? d_rsp_i : i_rsp_i;
            merged.hit          = d_rsp_i.hit | i_rsp_i.hit;
            merged.victim_dirty = 1'b0;
        end else if (s1_i_en_q) begin
            merged = i_rsp_i;
        end else begin
            merged = d_rsp_i;
        end
    end

    // Stage 2 valid and statistics
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
            stats_o     <= '0;
        end else begin
            rsp_valid_o <= s1_valid_q;
            if (s1_counted) begin
                if (merged.hit) begin
                    stats_o.hit_count <= stats_o.hit_count + 1'b1;
                end else begin
                    stats_o.miss_count <= stats_o.miss_count + 1'b1;
                end
            end
        end
    end

    // Stage 2 response payload
    always_ff @(posedge clk_i) begin
        if (s1_valid_q) begin
            rsp_o <= merged;
        end
    end

    // Only the five defined ops may be strobed in
    a_legal_op: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        cmd_valid_i |-> (cmd_i.op inside {OP_READ, OP_WRITE, OP_FETCH, OP_SNOOP_INV, OP_SNOOP_RD})
    ) else $error("command_router: undefined op strobed");

endmodule

// File: set_store.sv
// Cache set array
`timescale 1ns/100ps

module set_store #(
    parameter type  set_t     = cache_pkg::d_set_t,
    parameter set_t RESET_SET = '0
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           rd_en_i,
    input  logic [cache_pkg::INDEX_W-1:0]  rd_index_i,
    output set_t                           rd_set_o,
    input  logic                           wr_en_i,
    input  logic [cache_pkg::INDEX_W-1:0]  wr_index_i,
    input  set_t                           wr_set_i
);

    import cache_pkg::*;

    // One entry per set index
    set_t sets_q [NUM_SETS];

    // Write port, reset loads the cold contents into every set
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                sets_q[s] <= RESET_SET;
            end
        end else if (wr_en_i) begin
            sets_q[wr_index_i] <= wr_set_i;
        end
    end

    // Registered read port
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            // Same set written this cycle, take the new contents
            if (wr_en_i && (wr_index_i == rd_index_i)) begin
                rd_set_o <= wr_set_i;
            end else begin
                rd_set_o <= sets_q[rd_index_i];
            end
        end
    end

    // Write index comes from the way updater and must be resolved
    a_wr_index_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        wr_en_i |-> !$isunknown(wr_index_i)
    ) else $error("set_store: write with unknown index");

endmodule

// File: split_cache_top.sv
// Split L1 cache controller top
`timescale 1ns/100ps

module split_cache_top (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 cmd_valid_i,
    input  cache_pkg::command_t  cmd_i,
    output logic                 rsp_valid_o,
    output cache_pkg::rsp_t      rsp_o,
    output cache_pkg::stats_t    stats_o
);

    import cache_pkg::*;

    // Read side
    logic               d_rd_en;
    logic               i_rd_en;
    logic [INDEX_W-1:0] rd_index;
    d_set_t             d_rd_set;
    i_set_t             i_rd_set;

    // Lookup stage
    logic     d_lookup_en;
    logic     i_lookup_en;
    command_t stage_cmd;
    rsp_t     d_rsp;
    rsp_t     i_rsp;

    // Write back into the stores
    d_set_t             d_wr_set;
    i_set_t             i_wr_set;
    logic               d_wr_en;
    logic               i_wr_en;
    logic [INDEX_W-1:0] d_wr_index;
    logic [INDEX_W-1:0] i_wr_index;

    command_router u_router (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_i         (cmd_i),
        .d_rd_en_o     (d_rd_en),
        .i_rd_en_o     (i_rd_en),
        .rd_index_o    (rd_index),
        .d_lookup_en_o (d_lookup_en),
        .i_lookup_en_o (i_lookup_en),
        .stage_cmd_o   (stage_cmd),
        .d_rsp_i       (d_rsp),
        .i_rsp_i       (i_rsp),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_o         (rsp_o),
        .stats_o       (stats_o)
    );

    // Data cache, 8 ways
    set_store #(.set_t(d_set_t), .RESET_SET(D_RESET_SET)) u_d_store (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rd_en_i    (d_rd_en),
        .rd_index_i (rd_index),
        .rd_set_o   (d_rd_set),
        .wr_en_i    (d_wr_en),
        .wr_index_i (d_wr_index),
        .wr_set_i   (d_wr_set)
    );

    way_update #(.WAYS(D_WAYS), .set_t(d_set_t)) u_d_update (
        .lookup_en_i (d_lookup_en),
        .cmd_i       (stage_cmd),
        .set_i       (d_rd_set),
        .set_o       (d_wr_set),
        .wr_en_o     (d_wr_en),
        .wr_index_o  (d_wr_index),
        .rsp_o       (d_rsp)
    );

    // Instruction cache, 4 ways
    set_store #(.set_t(i_set_t), .RESET_SET(I_RESET_SET)) u_i_store (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rd_en_i    (i_rd_en),
        .rd_index_i (rd_index),
        .rd_set_o   (i_rd_set),
        .wr_en_i    (i_wr_en),
        .wr_index_i (i_wr_index),
        .wr_set_i   (i_wr_set)
    );

    way_update #(.WAYS(I_WAYS), .set_t(i_set_t)) u_i_update (
        .lookup_en_i (i_lookup_en),
        .cmd_i       (stage_cmd),
        .set_i       (i_rd_set),
        .set_o       (i_wr_set),
        .wr_en_o     (i_wr_en),
        .wr_index_o  (i_wr_index),
        .rsp_o       (i_rsp)
    );

endmodule

// File: tb_split_cache.sv
// Split cache testbench
`timescale 1ns/100ps

module tb_split_cache;

    import cache_pkg::*;

    // Table row, gap is the idle cycles after the strobe
    typedef struct packed {
        logic [8*12-1:0] name;
        command_t        cmd;
        rsp_t            rsp;
        stats_t          stats;
        logic [3:0]      gap;
    } entry_t;

    logic            clk;
    logic            rst_n;
    logic            cmd_valid;
    command_t        cmd;
    logic            rsp_valid;
    rsp_t            rsp;
    stats_t          stats;

    // Expectation driven together with each command
    logic [8*12-1:0] exp_name;
    rsp_t            exp_rsp;
    stats_t          exp_stats;

    int              pending;
    int              mismatch_count;
    int              missing_count;
    int              spurious_count;
    int              timeout_count;
    entry_t          table_q[$];

    // 40 ns clock
    initial clk = 1'b0;
    always #20 clk = ~clk;

    split_cache_top dut_i (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .stats_o     (stats)
    );

    cache_checker check_i (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .cmd_valid_i      (cmd_valid),
        .exp_name_i       (exp_name),
        .exp_rsp_i        (exp_rsp),
        .exp_stats_i      (exp_stats),
        .rsp_valid_i      (rsp_valid),
        .rsp_i            (rsp),
        .stats_i          (stats),
        .pending_o        (pending),
        .mismatch_count_o (mismatch_count),
        .missing_count_o  (missing_count),
        .spurious_count_o (spurious_count)
    );

    task automatic add_entry(input logic [8*12-1:0] name, input op_e op, input int tag,
                             input int index, input int hit, input int way, input mesi_e mesi,
                             input int dirty, input int instr, input int hits,
                             input int misses, input int gap);
        entry_t e;
        e.name                = name;
        e.cmd.op              = op;
        e.cmd.address.tag     = TAG_W'(tag);
        e.cmd.address.index   = INDEX_W'(index);
        // Offset varies per row and must never matter
        e.cmd.address.offset  = OFFSET_W'(table_q.size() * 5);
        e.rsp.hit             = (hit != 0);
        e.rsp.way             = WAY_W'(way);
        e.rsp.mesi            = mesi;
        e.rsp.victim_dirty    = (dirty != 0);
        e.rsp.is_instr        = (instr != 0);
        e.stats.hit_count     = CNT_W'(hits);
        e.stats.miss_count    = CNT_W'(misses);
        e.gap                 = 4'(gap);
        table_q.push_back(e);
    endtask

    task automatic build_table();
        // name, op, tag, index, hit, way, mesi, dirty, instr, hits, misses, gap
        // Cold fills of data set 3, lowest invalid way first
        add_entry("fill_w0", OP_READ, 'h100, 3, 0, 0, E, 0, 0, 0, 1, 0);
        add_entry("fill_w1", OP_READ, 'h101, 3, 0, 1, E, 0, 0, 0, 2, 0);
        add_entry("fill_w2", OP_READ, 'h102, 3, 0, 2, E, 0, 0, 0, 3, 1);
        add_entry("fill_w3", OP_READ, 'h103, 3, 0, 3, E, 0, 0, 0, 4, 0);
        add_entry("fill_w4", OP_READ, 'h104, 3, 0, 4, E, 0, 0, 0, 5, 0);
        add_entry("fill_w5", OP_READ, 'h105, 3, 0, 5, E, 0, 0, 0, 6, 2);
        add_entry("fill_w6", OP_READ, 'h106, 3, 0, 6, E, 0, 0, 0, 7, 0);
        add_entry("fill_w7", OP_READ, 'h107, 3, 0, 7, E, 0, 0, 0, 8, 1);
        // Hit on way 0 leaves way 1 as the oldest
        add_entry("hit_w0", OP_READ, 'h100, 3, 1, 0, E, 0, 0, 1, 8, 1);
        add_entry("evict_w1", OP_READ, 'h108, 3, 0, 1, E, 0, 0, 1, 9, 1);
        // Write hit makes way 2 modified
        add_entry("wr_hit_w2", OP_WRITE, 'h102, 3, 1, 2, M, 0, 0, 2, 9, 1);
        // Touch the oldest way each time until way 2 is oldest again
        add_entry("age_w3", OP_READ, 'h103, 3, 1, 3, E, 0, 0, 3, 9, 0);
        add_entry("age_w4", OP_READ, 'h104, 3, 1, 4, E, 0, 0, 4, 9, 0);
        add_entry("age_w5", OP_READ, 'h105, 3, 1, 5, E, 0, 0, 5, 9, 0);
        add_entry("age_w6", OP_READ, 'h106, 3, 1, 6, E, 0, 0, 6, 9, 0);
        add_entry("age_w7", OP_READ, 'h107, 3, 1, 7, E, 0, 0, 7, 9, 0);
        add_entry("age_w0", OP_READ, 'h100, 3, 1, 0, E, 0, 0, 8, 9, 0);
        add_entry("age_w1", OP_READ, 'h108, 3, 1, 1, E, 0, 0, 9, 9, 1);
        // Write miss evicts the modified line and allocates modified
        add_entry("wr_dirty_w2", OP_WRITE, 'h109, 3, 0, 2, M, 1, 0, 9, 10, 2);
        // Instruction set 5, four ways with their own ages
        add_entry("if_fill_w0", OP_FETCH, 'h200, 5, 0, 0, E, 0, 1, 9, 11, 0);
        add_entry("if_fill_w1", OP_FETCH, 'h201, 5, 0, 1, E, 0, 1, 9, 12, 0);
        add_entry("if_fill_w2", OP_FETCH, 'h202, 5, 0, 2, E, 0, 1, 9, 13, 0);
        add_entry("if_fill_w3", OP_FETCH, 'h203, 5, 0, 3, E, 0, 1, 9, 14, 1);
        add_entry("if_hit_w0", OP_FETCH, 'h200, 5, 1, 0, E, 0, 1, 10, 14, 1);
        add_entry("if_evict_w1", OP_FETCH, 'h204, 5, 0, 1, E, 0, 1, 10, 15, 2);
        // Snoops, never counted
        add_entry("snp_rd_m", OP_SNOOP_RD, 'h109, 3, 1, 2, S, 0, 0, 10, 15, 1);
        add_entry("snp_inv_w3", OP_SNOOP_INV, 'h103, 3, 1, 3, I, 0, 0, 10, 15, 1);
        add_entry("refill_w3", OP_READ, 'h103, 3, 0, 3, E, 0, 0, 10, 16, 1);
        // Absent tag, the instruction side answers with a miss
        add_entry("snp_inv_none", OP_SNOOP_INV, 'h3ff, 3, 0, 0, I, 0, 1, 10, 16, 1);
        add_entry("snp_rd_none", OP_SNOOP_RD, 'h3ff, 3, 0, 0, I, 0, 1, 10, 16, 1);
        add_entry("snp_rd_inst", OP_SNOOP_RD, 'h202, 5, 1, 2, S, 0, 1, 10, 16, 2);
        // Same address on consecutive cycles needs forwarding
        add_entry("b2b_write", OP_WRITE, 'h300, 9, 0, 0, M, 0, 0, 10, 17, 0);
        add_entry("b2b_read", OP_READ, 'h300, 9, 1, 0, M, 0, 0, 11, 17, 2);
    endtask

    initial begin
        int drain_cycles;
        int total;
        rst_n         = 1'b0;
        cmd_valid     = 1'b0;
        cmd           = '0;
        exp_name      = '0;
        exp_rsp       = '0;
        exp_stats     = '0;
        timeout_count = 0;
        build_table();

        // Reset held for 16 cycles, released mid-cycle
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int n = 0; n < table_q.size(); n++) begin
            cmd_valid = 1'b1;
            cmd       = table_q[n].cmd;
            exp_name  = table_q[n].name;
            exp_rsp   = table_q[n].rsp;
            exp_stats = table_q[n].stats;
            @(negedge clk);
            cmd_valid = 1'b0;
            repeat (int'(table_q[n].gap)) @(negedge clk);
        end

        // Drain outstanding responses
        drain_cycles = 0;
        while (pending != 0 && drain_cycles < 50) begin
            @(negedge clk);
            drain_cycles = drain_cycles + 1;
        end
        if (pending != 0) begin
            timeout_count = timeout_count + 1;
            $display("Timeout: %0d responses still outstanding after 50 cycles", pending);
        end
        // A few quiet cycles to catch late extra responses
        repeat (3) @(negedge clk);

        total = mismatch_count + missing_count + spurious_count + timeout_count;
        $display("Errors: mismatch=%0d missing=%0d spurious=%0d timeout=%0d",
                 mismatch_count, missing_count, spurious_count, timeout_count);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
cache_pkg.sv
set_store.sv
way_update.sv
command_router.sv
split_cache_top.sv
cache_checker.sv
tb_split_cache.sv

// File: way_update.sv
// Per-side way lookup and update
`timescale 1ns/100ps

module way_update #(
    parameter int  WAYS  = 8,
    parameter type set_t = cache_pkg::d_set_t
) (
    input  logic                           lookup_en_i,
    input  cache_pkg::command_t            cmd_i,
    input  set_t                           set_i,
    output set_t                           set_o,
    output logic                           wr_en_o,
    output logic [cache_pkg::INDEX_W-1:0]  wr_index_o,
    output cache_pkg::rsp_t                rsp_o
);

    import cache_pkg::*;

    localparam int IDX_W = $clog2(WAYS);

    logic [WAYS-1:0]  hit_vec;
    logic             hit;
    logic [IDX_W-1:0] hit_way;
    logic [IDX_W-1:0] inv_way;
    logic             found_inv;
    logic [IDX_W-1:0] oldest_way;
    logic [AGE_W-1:0] oldest_age;
    logic [IDX_W-1:0] victim_way;
    logic [IDX_W-1:0] sel_way;
    logic [AGE_W-1:0] touched_age;
    logic             is_snoop;
    mesi_e            new_mesi;
    logic             ages_unique;

    // Tag compare on valid lines only
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = (set_i[w].mesi != I) && (set_i[w].tag == cmd_i.address.tag);
        end
    end

    assign hit = |hit_vec;

    // Encode the hitting way
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way = IDX_W'(w);
            end
        end
    end

    // Victim search
    always_comb begin
        // Oldest line by age
        oldest_way = '0;
        oldest_age = set_i[0].age;
        for (int w = 1; w < WAYS; w++) begin
            if (set_i[w].age > oldest_age) begin
                oldest_age = set_i[w].age;
                oldest_way = IDX_W'(w);
            end
        end
        // Walk downward so the lowest invalid way wins
        inv_way   = '0;
        found_inv = 1'b0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (set_i[w].mesi == I) begin
                inv_way   = IDX_W'(w);
                found_inv = 1'b1;
            end
        end
        victim_way = found_inv ? inv_way : oldest_way;
    end

    assign sel_way     = hit ? hit_way : victim_way;
    assign touched_age = set_i[sel_way].age;
    assign is_snoop    = cmd_i.op inside {OP_SNOOP_INV, OP_SNOOP_RD};
    assign wr_index_o  = cmd_i.address.index;

    // MESI next state of the selected way
    always_comb begin
        new_mesi = set_i[sel_way].mesi;
        case (cmd_i.op)
            OP_SNOOP_INV: if (hit) new_mesi = I;
            // Another reader appears, exclusive ownership is lost
            OP_SNOOP_RD: begin
                if (hit && (set_i[sel_way].mesi inside {M, E})) begin
                    new_mesi = S;
                end
            end
            OP_WRITE: new_mesi = M;
            // Read and fetch allocate clean, hits keep their state
            default: if (!hit) new_mesi = E;
        endcase
    end

    // Set update and response
    always_comb begin
        set_o   = set_i;
        wr_en_o = 1'b0;
        rsp_o   = '0;
        if (lookup_en_i) begin
            if (is_snoop) begin
                // Snoop changes state only, ages untouched
                if (hit) begin
                    set_o[sel_way].mesi = new_mesi;
                    wr_en_o             = 1'b1;
                end
            end else begin
                // Ages younger than the touched one step up by one
                for (int w = 0; w < WAYS; w++) begin
                    if (set_i[w].age < touched_age) begin
                        set_o[w].age = set_i[w].age + 1'b1;
                    end
                end
                set_o[sel_way].age  = '0;
                set_o[sel_way].tag  = cmd_i.address.tag;
                set_o[sel_way].mesi = new_mesi;
                wr_en_o             = 1'b1;
            end
            rsp_o.hit          = hit;
            rsp_o.way          = (is_snoop && !hit) ? '0 : WAY_W'(sel_way);
            rsp_o.mesi         = (is_snoop && !hit) ? I : new_mesi;
            // Evicting a modified line would need a write-back
            rsp_o.victim_dirty = !is_snoop && !hit && (set_i[sel_way].mesi == M);
            rsp_o.is_instr     = (WAYS == I_WAYS);
        end
    end

    // Age permutation check over the written set
    always_comb begin
        ages_unique = 1'b1;
        for (int a = 0; a < WAYS; a++) begin
            for (int b = a + 1; b < WAYS; b++) begin
                if (set_o[a].age == set_o[b].age) begin
                    ages_unique = 1'b0;
                end
            end
        end
    end

    always_comb begin
        if (lookup_en_i) begin
            a_single_hit: assert final ($onehot0(hit_vec))
                else $error("way_update: tag hit in more than one way");
            a_ages_distinct: assert final (!wr_en_o || ages_unique)
                else $error("way_update: duplicate ages in written set");
        end
    end

endmodule
